// File: Bender.yml
package:
  name: merge_data_engine

sources:
  - files:
      - hdl/merge_pkg.sv
      - hdl/merge_ctrl_if.sv
      - hdl/merge_fifo.sv
      - hdl/merge_round_counter.sv
      - hdl/merge_control_fsm.sv
      - hdl/merge_packer.sv
      - hdl/merge_data_engine.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/merge_data_engine_props.sv
      - testbench/tb_merge_data_engine.sv

// File: flist.f
hdl/merge_pkg.sv
hdl/merge_ctrl_if.sv
hdl/merge_fifo.sv
hdl/merge_round_counter.sv
hdl/merge_control_fsm.sv
hdl/merge_packer.sv
hdl/merge_data_engine.sv
testbench/tb_clock_gen.sv
testbench/merge_data_engine_props.sv
testbench/tb_merge_data_engine.sv

// File: hdl/merge_control_fsm.sv
// Job FSM that takes the descriptor, pops the configuration and runs the gather rounds
`timescale 1ns/100ps
`default_nettype none

module merge_control_fsm (
    input  logic                    ap_clk,
    input  logic                    areset_merge_data_engine,
    input  logic                    descriptor_valid,
    input  merge_pkg::count_t       descriptor_count,
    input  logic                    config_empty,
    input  merge_pkg::config_word_t config_word,
    output logic                    config_rd_en,
    output logic                    done_out,
    merge_ctrl_if.fsm               ctrl
);

    merge_pkg::merge_state_t state;
    merge_pkg::merge_state_t state_next;
    // Round count of the accepted descriptor
    merge_pkg::count_t       job_count;
    // Configuration word is at the head of its FIFO
    logic                    config_take;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    assign config_take = (state == merge_pkg::LOAD_CONFIG) & ~config_empty;

    always_comb begin
        state_next = state;
        case (state)
            merge_pkg::IDLE: begin
                // Descriptors outside IDLE are ignored
                if (descriptor_valid) begin
                    state_next = merge_pkg::LOAD_CONFIG;
                end
            end
            merge_pkg::LOAD_CONFIG: begin
                // Zero rounds finish without a packet
                if (config_take) begin
                    state_next = (job_count == '0) ? merge_pkg::IDLE : merge_pkg::GATHER;
                end
            end
            merge_pkg::GATHER: begin
                if (ctrl.fire && ctrl.last_round) begin
                    state_next = merge_pkg::IDLE;
                end
            end
            default: state_next = merge_pkg::IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // State, lane mask and done level
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            state          <= merge_pkg::IDLE;
            ctrl.lane_mask <= '0;
            done_out       <= 1'b1;
        end
        else begin
            state <= state_next;
            if (config_take) begin
                ctrl.lane_mask <= config_word.lane_mask;
            end
            // Follows the state by one cycle
            done_out <= (state == merge_pkg::IDLE);
        end
    end

    // Count held for the load pulse
    always_ff @(posedge ap_clk) begin
        if ((state == merge_pkg::IDLE) && descriptor_valid) begin
            job_count <= descriptor_count;
        end
    end

    assign config_rd_en     = config_take;
    assign ctrl.load        = config_take;
    assign ctrl.round_count = job_count;
    assign ctrl.gather_en   = (state == merge_pkg::GATHER);

endmodule : merge_control_fsm

`default_nettype wire

// File: hdl/merge_ctrl_if.sv
// Control bundle between the merge FSM, the round counter and the packer
`timescale 1ns/100ps
`default_nettype none

interface merge_ctrl_if;

    // Counter load pulse and the count it takes
    logic                  load;
    merge_pkg::count_t     round_count;
    // High while one round is left
    logic                  last_round;
    // Lanes that take part in the current job
    merge_pkg::lane_mask_t lane_mask;
    // FSM sits in GATHER
    logic                  gather_en;
    // One round merged this cycle
    logic                  fire;

    modport fsm (
        output load, round_count, lane_mask, gather_en,
        input  fire, last_round
    );

    modport counter (
        input  load, round_count, fire,
        output last_round
    );

    modport packer (
        input  lane_mask, gather_en,
        output fire
    );

endinterface : merge_ctrl_if

`default_nettype wire

// File: hdl/merge_data_engine.sv
// Merge-data engine top that gathers lane words into wide request packets per round
`timescale 1ns/100ps
`default_nettype none

module merge_data_engine #(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       ap_clk,
    input  logic                       areset_merge_data_engine,
    input  logic                       descriptor_valid,
    input  merge_pkg::count_t          descriptor_count,
    input  logic                       config_valid,
    input  merge_pkg::lane_mask_t      config_mask,
    input  logic                       lane_valid [NUM_LANES-1:0],
    input  merge_pkg::lane_word_t      lane_data  [NUM_LANES-1:0],
    output logic                       lane_full  [NUM_LANES-1:0],
    output logic                       config_full,
    input  logic                       request_ready,
    output logic                       request_valid,
    output merge_pkg::request_packet_t request_packet,
    output logic                       done_out
);

    // ------------------------------------------------------------
    // Boundary registers
    // ------------------------------------------------------------
    logic                    areset_reg;
    logic                    descriptor_valid_reg;
    merge_pkg::count_t       descriptor_count_reg;
    logic                    config_valid_reg;
    merge_pkg::config_word_t config_word_reg;
    logic                    lane_valid_reg [NUM_LANES-1:0];
    merge_pkg::lane_word_t   lane_data_reg  [NUM_LANES-1:0];

    // FIFO outputs and pops
    logic                    lane_empty [NUM_LANES-1:0];
    logic                    lane_rd_en [NUM_LANES-1:0];
    merge_pkg::lane_word_t   lane_head  [NUM_LANES-1:0];
    logic                    config_empty;
    logic                    config_rd_en;
    merge_pkg::config_word_t config_head;

    merge_ctrl_if ctrl_if ();

    // Single registered reset for the whole engine
    always_ff @(posedge ap_clk) begin
        areset_reg <= areset_merge_data_engine;
    end

    // Strobes
    always_ff @(posedge ap_clk) begin
        if (areset_reg) begin
            descriptor_valid_reg <= 1'b0;
            config_valid_reg     <= 1'b0;
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_valid_reg[i] <= 1'b0;
            end
        end
        else begin
            descriptor_valid_reg <= descriptor_valid;
            config_valid_reg     <= config_valid;
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_valid_reg[i] <= lane_valid[i];
            end
        end
    end

    // Payloads
    always_ff @(posedge ap_clk) begin
        descriptor_count_reg      <= descriptor_count;
        config_word_reg.lane_mask <= config_mask;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_data_reg[i] <= lane_data[i];
        end
    end

    // ------------------------------------------------------------
    // Lane and configuration FIFOs
    // ------------------------------------------------------------
    for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane_fifo
        merge_fifo #(
            .payload_t (merge_pkg::lane_word_t),
            .FIFO_DEPTH(FIFO_DEPTH            )
        ) lane_fifo_inst (
            .ap_clk                  (ap_clk           ),
            .areset_merge_data_engine(areset_reg       ),
            .wr_en                   (lane_valid_reg[g]),
            .wr_data                 (lane_data_reg[g] ),
            .rd_en                   (lane_rd_en[g]    ),
            .rd_data                 (lane_head[g]     ),
            .empty                   (lane_empty[g]    ),
            .full                    (lane_full[g]     )
        );
    end

    merge_fifo #(
        .payload_t (merge_pkg::config_word_t),
        .FIFO_DEPTH(FIFO_DEPTH              )
    ) config_fifo_inst (
        .ap_clk                  (ap_clk          ),
        .areset_merge_data_engine(areset_reg      ),
        .wr_en                   (config_valid_reg),
        .wr_data                 (config_word_reg ),
        .rd_en                   (config_rd_en    ),
        .rd_data                 (config_head     ),
        .empty                   (config_empty    ),
        .full                    (config_full     )
    );

    // ------------------------------------------------------------
    // Control and merge
    // ------------------------------------------------------------
    merge_round_counter round_counter_inst (
        .ap_clk                  (ap_clk    ),
        .areset_merge_data_engine(areset_reg),
        .ctrl                    (ctrl_if   )
    );

    merge_control_fsm control_fsm_inst (
        .ap_clk                  (ap_clk              ),
        .areset_merge_data_engine(areset_reg          ),
        .descriptor_valid        (descriptor_valid_reg),
        .descriptor_count        (descriptor_count_reg),
        .config_empty            (config_empty        ),
        .config_word             (config_head         ),
        .config_rd_en            (config_rd_en        ),
        .done_out                (done_out            ),
        .ctrl                    (ctrl_if             )
    );

    merge_packer #(
        .NUM_LANES(NUM_LANES)
    ) packer_inst (
        .ap_clk                  (ap_clk        ),
        .areset_merge_data_engine(areset_reg    ),
        .lane_empty              (lane_empty    ),
        .lane_data               (lane_head     ),
        .lane_rd_en              (lane_rd_en    ),
        .request_ready           (request_ready ),
        .request_valid           (request_valid ),
        .request_packet          (request_packet),
        .ctrl                    (ctrl_if       )
    );

endmodule : merge_data_engine

`default_nettype wire

// File: hdl/merge_fifo.sv
// First-word-fall-through FIFO with a payload type parameter and a full level
`timescale 1ns/100ps
`default_nettype none

module merge_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 8
) (
    input  logic     ap_clk,
    input  logic     areset_merge_data_engine,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     rd_en,
    output payload_t rd_data,
    output logic     empty,
    output logic     full
);

    // Pointer and occupancy widths, a depth of one still gets a 1-bit pointer
    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    payload_t               mem [FIFO_DEPTH-1:0];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [CNT_WIDTH-1:0]   count;
    logic                   wr_accept;
    logic                   rd_accept;

    // Writes into a full FIFO and reads from an empty one are dropped
    assign wr_accept = wr_en & ~full;
    assign rd_accept = rd_en & ~empty;

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            // Wrap by compare so any depth works
            if (wr_accept) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (wr_accept & ~rd_accept) begin
                count <= count + 1'b1;
            end
            else if (rd_accept & ~wr_accept) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head word shows as soon as it lands
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    // Rises the cycle after the filling write
    assign full    = (count == CNT_WIDTH'(FIFO_DEPTH));

endmodule : merge_fifo

`default_nettype wire

// File: hdl/merge_packer.sv
// Packer that fires rounds, pops the selected lanes and registers the request packet
`timescale 1ns/100ps
`default_nettype none

module merge_packer #(
    parameter int NUM_LANES = 4
) (
    input  logic                       ap_clk,
    input  logic                       areset_merge_data_engine,
    input  logic                       lane_empty [NUM_LANES-1:0],
    input  merge_pkg::lane_word_t      lane_data  [NUM_LANES-1:0],
    output logic                       lane_rd_en [NUM_LANES-1:0],
    input  logic                       request_ready,
    output logic                       request_valid,
    output merge_pkg::request_packet_t request_packet,
    merge_ctrl_if.packer               ctrl
);

    // Per lane, either not selected or holding a word
    logic [NUM_LANES-1:0]       lane_ok;
    merge_pkg::request_packet_t packet_next;

    // ------------------------------------------------------------
    // Fire decision and lane pops
    // ------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_ok[i] = ~ctrl.lane_mask[i] | ~lane_empty[i];
        end
    end

    // Empty mask fires on ready alone
    assign ctrl.fire = ctrl.gather_en & request_ready & (&lane_ok);

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_rd_en[i] = ctrl.fire & ctrl.lane_mask[i];
        end
    end

    // Selected fields carry the lane heads, the rest stay zero
    always_comb begin
        packet_next = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ctrl.lane_mask[i]) begin
                packet_next[i] = lane_data[i];
            end
        end
    end

    // ------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            request_valid <= 1'b0;
        end
        else begin
            // One cycle per fire
            request_valid <= ctrl.fire;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ctrl.fire) begin
            request_packet <= packet_next;
        end
    end

endmodule : merge_packer

`default_nettype wire

// File: hdl/merge_pkg.sv
// Merge-data engine shared widths, payload types and FSM state encoding
`default_nettype none

package merge_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    // Fields in one request packet
    parameter int MAX_LANES   = 4;
    // Bits in one engine response word
    parameter int LANE_WIDTH  = 16;
    // Bits in the round count of a descriptor
    parameter int COUNT_WIDTH = 8;

    // ------------------------------------------------------------
    // Payload types
    // ------------------------------------------------------------
    typedef logic [LANE_WIDTH-1:0]  lane_word_t;
    typedef logic [MAX_LANES-1:0]   lane_mask_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // Configuration memory response, only the lane select for now
    typedef struct packed {
        lane_mask_t lane_mask;
    } config_word_t;

    // Lane i occupies bits 16i upward
    typedef lane_word_t [MAX_LANES-1:0] request_packet_t;

    // Control sequence of one job
    typedef enum logic [1:0] {
        IDLE,
        LOAD_CONFIG,
        GATHER
    } merge_state_t;

endpackage : merge_pkg

`default_nettype wire

// File: hdl/merge_round_counter.sv
// Round counter that loads the job count and flags the last round
`timescale 1ns/100ps
`default_nettype none

module merge_round_counter (
    input  logic   ap_clk,
    input  logic   areset_merge_data_engine,
    merge_ctrl_if.counter ctrl
);

    // Rounds still to fire in this job
    merge_pkg::count_t remaining;

    always_ff @(posedge ap_clk) begin
        if (areset_merge_data_engine) begin
            remaining <= '0;
        end
        else if (ctrl.load) begin
            remaining <= ctrl.round_count;
        end
        else if (ctrl.fire && (remaining != '0)) begin
            // One round merged
            remaining <= remaining - 1'b1;
        end
    end

    // Fire with this set closes the job
    assign ctrl.last_round = (remaining == merge_pkg::count_t'(1));

endmodule : merge_round_counter

`default_nettype wire

// File: testbench/merge_data_engine_props.sv
// Output protocol assertions for the merge-data engine, bound into the top level
`timescale 1ns/100ps
`default_nettype none

module merge_data_engine_props (
    input wire logic ap_clk,
    input wire logic engine_reset,
    input wire logic fire,
    input wire logic request_valid,
    input wire logic done_out
);

    // ------------------------------------------------------------
    // Reset
    // ------------------------------------------------------------
    // Packer output is cleared by the registered reset
    no_valid_in_reset: assert property (
        @(posedge ap_clk) engine_reset |=> !request_valid
    ) else $error("request_valid high while the engine is in reset");

    // ------------------------------------------------------------
    // Packet protocol
    // ------------------------------------------------------------
    // A packet in flight means the FSM left IDLE
    done_low_in_flight: assert property (
        @(posedge ap_clk) disable iff (engine_reset)
        request_valid |-> !done_out
    ) else $error("done_out high while a packet is on the output");

    // Each valid cycle comes from a fire in the cycle before
    valid_follows_fire: assert property (
        @(posedge ap_clk) disable iff (engine_reset)
        request_valid |-> $past(fire)
    ) else $error("request_valid without a fire in the cycle before");

    // Every fire shows as one valid cycle
    fire_gives_valid: assert property (
        @(posedge ap_clk) disable iff (engine_reset)
        fire |=> request_valid
    ) else $error("fire without request_valid in the next cycle");

endmodule : merge_data_engine_props

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Free-running testbench clock source for the merge-data engine
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic ap_clk
);

    // Starts low, toggles every half period
    initial begin
        ap_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) ap_clk = ~ap_clk;
        end
    end

endmodule : tb_clock_gen

`default_nettype wire

// File: testbench/tb_merge_data_engine.sv
// Testbench for the merge-data engine with random lane traffic and a queue model
`timescale 1ns/100ps
`default_nettype none

module tb_merge_data_engine;

    localparam int NUM_LANES       = 4;
    localparam int FIFO_DEPTH      = 8;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 4;
    localparam int WAIT_LIMIT      = 2000;
    localparam int HOLD_CYCLES     = 24;
    localparam int NUM_RANDOM_JOBS = 10;
    localparam int SEED            = 32'h452c6b1c;

    logic                       ap_clk;
    logic                       areset_merge_data_engine;
    logic                       descriptor_valid;
    merge_pkg::count_t          descriptor_count;
    logic                       config_valid;
    merge_pkg::lane_mask_t      config_mask;
    logic                       lane_valid [NUM_LANES-1:0];
    merge_pkg::lane_word_t      lane_data  [NUM_LANES-1:0];
    logic                       lane_full  [NUM_LANES-1:0];
    logic                       config_full;
    logic                       request_ready;
    logic                       request_valid;
    merge_pkg::request_packet_t request_packet;
    logic                       done_out;

    // ------------------------------------------------------------
    // Model state
    // ------------------------------------------------------------
    // Words sent per lane, in send order
    merge_pkg::lane_word_t lane_model [NUM_LANES][$];
    merge_pkg::lane_mask_t config_model [$];
    // Words sent and words seen in packets, bounds the FIFO level
    int                    lane_pushed   [NUM_LANES];
    int                    lane_consumed [NUM_LANES];
    merge_pkg::lane_mask_t job_mask;
    int                    job_count;
    int                    job_received;
    // 0 random, 1 held low, 2 held high
    int                    ready_mode;
    logic                  stim_stop;

    tb_clock_gen #(
        .PERIOD_NS(8.0)
    ) clock_gen_inst (
        .ap_clk(ap_clk)
    );

    merge_data_engine #(
        .NUM_LANES (NUM_LANES ),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) merge_data_engine_inst (
        .ap_clk                  (ap_clk                  ),
        .areset_merge_data_engine(areset_merge_data_engine),
        .descriptor_valid        (descriptor_valid        ),
        .descriptor_count        (descriptor_count        ),
        .config_valid            (config_valid            ),
        .config_mask             (config_mask             ),
        .lane_valid              (lane_valid              ),
        .lane_data               (lane_data               ),
        .lane_full               (lane_full               ),
        .config_full             (config_full             ),
        .request_ready           (request_ready           ),
        .request_valid           (request_valid           ),
        .request_packet          (request_packet          ),
        .done_out                (done_out                )
    );

    // Protocol checks on the engine's own registered reset
    bind merge_data_engine merge_data_engine_props props_inst (
        .ap_clk       (ap_clk       ),
        .engine_reset (areset_reg   ),
        .fire         (ctrl_if.fire ),
        .request_valid(request_valid),
        .done_out     (done_out     )
    );

    // ------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------
    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, expected);
            stop_on_error("Value mismatch");
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus and monitor
    // ------------------------------------------------------------
    // Lane words and ready, never past the FIFO depth
    task automatic drive_stimulus();
        while (!stim_stop) begin
            @(posedge ap_clk);
            #DRIVE_DELAY;
            for (int i = 0; i < NUM_LANES; i++) begin
                if ((lane_pushed[i] - lane_consumed[i] < FIFO_DEPTH) &&
                    ($urandom_range(1, 0) == 1)) begin
                    lane_valid[i] = 1'b1;
                    lane_data[i]  = merge_pkg::lane_word_t'($urandom);
                    lane_model[i].push_back(lane_data[i]);
                    lane_pushed[i]++;
                end
                else begin
                    lane_valid[i] = 1'b0;
                end
            end
            case (ready_mode)
                0:       request_ready = ($urandom_range(3, 0) != 0);
                1:       request_ready = 1'b0;
                default: request_ready = 1'b1;
            endcase
        end
    endtask

    // Predicts each packet from the lane queues as it arrives
    task automatic monitor_packets();
        merge_pkg::request_packet_t expected;
        while (!stim_stop) begin
            @(negedge ap_clk);
            if (request_valid === 1'b1) begin
                job_received++;
                if (job_received > job_count) begin
                    stop_on_error("Packet arrived beyond the round count of the job");
                end
                expected = '0;
                for (int i = 0; i < NUM_LANES; i++) begin
                    if (job_mask[i]) begin
                        if (lane_model[i].size() == 0) begin
                            stop_on_error("Packet arrived before its lane word was sent");
                        end
                        expected[i] = lane_model[i].pop_front();
                        lane_consumed[i]++;
                    end
                end
                check_value("request_packet", request_packet, expected);
            end
        end
    endtask

    // ------------------------------------------------------------
    // One job from descriptor to done
    // ------------------------------------------------------------
    task automatic run_job(input merge_pkg::lane_mask_t mask, input int count,
                           input logic hold_ready);
        int   cycles;
        logic seen_low;
        // Descriptors are only taken in IDLE
        cycles = 0;
        @(negedge ap_clk);
        while (done_out !== 1'b1) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("Timed out waiting for the engine to go idle");
            end
            @(negedge ap_clk);
        end
        if (hold_ready) begin
            ready_mode = 1;
        end
        config_model.push_back(mask);
        job_mask     = config_model.pop_front();
        job_count    = count;
        job_received = 0;
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_valid     = 1'b1;
        config_mask      = mask;
        descriptor_valid = 1'b1;
        descriptor_count = merge_pkg::count_t'(count);
        @(posedge ap_clk);
        #DRIVE_DELAY;
        config_valid     = 1'b0;
        descriptor_valid = 1'b0;
        // Job start shows as done_out falling
        seen_low = 1'b0;
        cycles   = 0;
        while (!seen_low) begin
            @(negedge ap_clk);
            if (done_out === 1'b0) begin
                seen_low = 1'b1;
            end
            else begin
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    stop_on_error("Timed out waiting for the job to start");
                end
            end
        end
        // Nothing may fire while ready is low
        if (hold_ready) begin
            for (int k = 0; k < HOLD_CYCLES; k++) begin
                @(negedge ap_clk);
                check_value("request_valid", request_valid, 1'b0);
            end
            ready_mode = 2;
        end
        // Done rises one cycle after the last packet
        cycles = 0;
        while (done_out !== 1'b1) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                stop_on_error("Timed out waiting for the job to finish");
            end
            @(negedge ap_clk);
        end
        check_value("job_received", job_received, job_count);
        ready_mode = 0;
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        areset_merge_data_engine = 1'b1;
        descriptor_valid         = 1'b0;
        descriptor_count         = '0;
        config_valid             = 1'b0;
        config_mask              = '0;
        request_ready            = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_valid[i]    = 1'b0;
            lane_data[i]     = '0;
            lane_pushed[i]   = 0;
            lane_consumed[i] = 0;
        end
        job_mask     = '0;
        job_count    = 0;
        job_received = 0;
        ready_mode   = 0;
        stim_stop    = 1'b0;

        repeat (RESET_CYCLES) @(posedge ap_clk);
        #DRIVE_DELAY;
        areset_merge_data_engine = 1'b0;

        // Output levels straight after reset
        @(negedge ap_clk);
        check_value("request_valid", request_valid, 1'b0);
        check_value("done_out", done_out, 1'b1);
        check_value("config_full", config_full, 1'b0);
        for (int i = 0; i < NUM_LANES; i++) begin
            check_value($sformatf("lane_full[%0d]", i), lane_full[i], 1'b0);
        end

        fork
            drive_stimulus();
            monitor_packets();
        join_none

        // Full mask, partial masks, zero count, ready held low, empty mask
        run_job(4'hf, 6, 1'b0);
        run_job(4'b0101, 4, 1'b0);
        run_job(4'b1010, 3, 1'b0);
        run_job(4'hf, 0, 1'b0);
        run_job(4'b1011, 5, 1'b1);
        run_job(4'h0, 3, 1'b0);
        for (int j = 0; j < NUM_RANDOM_JOBS; j++) begin
            run_job(merge_pkg::lane_mask_t'($urandom_range(15, 0)),
                    $urandom_range(7, 0), ($urandom_range(3, 0) == 0));
        end

        stim_stop = 1'b1;
        repeat (2) @(posedge ap_clk);
        $display("Test passed");
        $finish;
    end

endmodule : tb_merge_data_engine

`default_nettype wire
